//--- flist.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_req_buf.sv
rtl/icache_tagv_lru.sv
rtl/icache_data_array.sv
rtl/icache_ctrl_fsm.sv
rtl/icache_rdata_sel.sv
rtl/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

//--- verif/icache_tb.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int          RESET_CYCLES = 5;
    localparam logic [31:0] LINE_MASK    = (32'd1 << (`ICACHE_OFFSET_W + 2)) - 32'd1;

    typedef struct packed {
        logic [31:0] addr;
        logic        flush;         // flush high while this entry is presented
        logic        exp_miss;
    } stim_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        exp_miss;
        logic [31:0] acc_cycle;
    } pend_t;

    logic          clk;
    logic          rstn;
    logic          req_valid;
    icache_req_t   req;
    logic          req_ready;
    logic          flush;
    logic          rdata_valid;
    icache_resp_t  rdata;
    logic          mem_req_valid;
    mem_req_t      mem_req;
    logic          mem_addr_ok;
    logic          mem_data_ok;
    mem_resp_t     mem_rdata;

    stim_t stim_q[$];
    pend_t pend_q[$];               // accepted with answer still due
    int    cycle;
    int    hs_since_resp;
    int    hs_total;
    int    hit_cnt;
    int    miss_cnt;

    icache_top icache_top_i (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .flush         (flush),
        .rdata_valid   (rdata_valid),
        .rdata         (rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    icache_mem_model u_mem_model (
        .clk           (clk),
        .rstn          (rstn),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_rdata     (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped in cycle %0d", cycle);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [31:0] word;
        word = (addr >> 2) & ((32'd1 << `ICACHE_OFFSET_W) - 32'd1);
        return ((addr & ~LINE_MASK) + 4 * word) ^ 32'h5a5a_0000;
    endfunction

    task automatic add_entry(input logic [31:0] addr, input logic fl, input logic miss);
        stim_t s;
        s.addr     = addr;
        s.flush    = fl;
        s.exp_miss = miss;
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        add_entry(32'h0000_0104, 1'b0, 1'b1);   // cold
        add_entry(32'h0000_0108, 1'b0, 1'b0);
        add_entry(32'h0000_010c, 1'b0, 1'b0);
        add_entry(32'h0000_0100, 1'b0, 1'b0);
        // set 5 sequence A B A C B A B
        add_entry(32'h0000_1050, 1'b0, 1'b1);
        add_entry(32'h0000_2054, 1'b0, 1'b1);
        add_entry(32'h0000_1058, 1'b0, 1'b0);
        add_entry(32'h0000_305c, 1'b0, 1'b1);   // C evicts B
        add_entry(32'h0000_2050, 1'b0, 1'b1);   // B evicts A
        add_entry(32'h0000_1054, 1'b0, 1'b1);   // A evicts C
        add_entry(32'h0000_2058, 1'b0, 1'b0);
        // a miss and a hit squashed in lookup plus dropped requests
        add_entry(32'h0000_4070, 1'b0, 1'b0);
        add_entry(32'h0000_0104, 1'b1, 1'b0);
        add_entry(32'h0000_1050, 1'b1, 1'b0);
        add_entry(32'h0000_0108, 1'b0, 1'b0);
        add_entry(32'h0000_0100, 1'b1, 1'b0);
        add_entry(32'h0000_4074, 1'b0, 1'b1);   // squashed line never filled
        // hit stream with misses in between
        add_entry(32'h0000_0100, 1'b0, 1'b0);
        add_entry(32'h0000_0104, 1'b0, 1'b0);
        add_entry(32'h0000_1050, 1'b0, 1'b0);
        add_entry(32'h0000_205c, 1'b0, 1'b0);
        add_entry(32'h0000_0200, 1'b0, 1'b1);   // second way of set 0
        add_entry(32'h0000_0108, 1'b0, 1'b0);
        add_entry(32'h0000_020c, 1'b0, 1'b0);
        add_entry(32'h0000_4078, 1'b0, 1'b0);
        add_entry(32'h0000_0310, 1'b0, 1'b1);
        add_entry(32'h0000_0314, 1'b0, 1'b0);
        add_entry(32'h0000_0318, 1'b0, 1'b0);
        add_entry(32'h0000_010c, 1'b0, 1'b0);
    endtask

    //////////////////////////////
    // stimulus and scoreboard
    //////////////////////////////

    initial begin
        pend_t p;
        int    limit;
        int    idx;
        int    i;
        int    exp_hits;
        int    exp_misses;

        rstn          = 1'b0;
        req_valid     = 1'b0;
        req           = '0;
        flush         = 1'b0;
        cycle         = 0;
        hs_since_resp = 0;
        hs_total      = 0;
        hit_cnt       = 0;
        miss_cnt      = 0;
        exp_hits      = 0;
        exp_misses    = 0;
        build_table();
        limit = RESET_CYCLES + 2 + stim_q.size() * 12;

        // answered entries have flush low now and in their lookup cycle
        for (i = 0; i < stim_q.size(); i++) begin
            if (!stim_q[i].flush && (i + 1 == stim_q.size() || !stim_q[i + 1].flush)) begin
                if (stim_q[i].exp_miss) begin
                    exp_misses++;
                end else begin
                    exp_hits++;
                end
            end
        end

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            check_val("req_ready", req_ready, 1'b0);
            check_val("mem_req_valid", mem_req_valid, 1'b0);
            check_val("rdata_valid", rdata_valid, 1'b0);
        end
        idx = 0;
        rstn      <= 1'b1;
        req_valid <= 1'b1;
        req.addr  <= stim_q[0].addr;
        flush     <= stim_q[0].flush;
        @(posedge clk);
        check_val("req_ready", req_ready, 1'b0);    // release flop still low
        check_val("mem_req_valid", mem_req_valid, 1'b0);
        check_val("rdata_valid", rdata_valid, 1'b0);

        while (idx < stim_q.size() || pend_q.size() != 0) begin
            @(posedge clk);
            cycle++;
            if (cycle > limit) begin
                stop_run("Timeout: the cache stopped answering within the cycle limit");
            end
            // the request taken last cycle is in lookup now
            if (pend_q.size() != 0 && pend_q[$].acc_cycle == cycle - 1) begin
                if (flush) begin
                    void'(pend_q.pop_back());
                    check_val("mem_req_valid", mem_req_valid, 1'b0);
                end else begin
                    check_val("mem_req_valid", mem_req_valid, pend_q[$].exp_miss);
                end
            end
            if (mem_req_valid && mem_addr_ok) begin
                if (pend_q.size() == 0) begin
                    stop_run("Memory request issued with no fetch request outstanding");
                end else begin
                    check_val("mem_req.addr", mem_req.addr, pend_q[0].addr & ~LINE_MASK);
                    hs_since_resp++;
                    hs_total++;
                end
            end
            if (rdata_valid) begin
                if (pend_q.size() == 0) begin
                    stop_run("rdata_valid raised with no request outstanding");
                end else begin
                    p = pend_q.pop_front();
                    check_val("rdata", rdata.data, expected_word(p.addr));
                    check_val("memory handshakes", hs_since_resp, p.exp_miss);
                    check_val("req_ready", req_ready, 1'b1);    // next request taken with the answer
                    hs_since_resp = 0;
                    if (p.exp_miss) begin
                        miss_cnt++;
                    end else begin
                        check_val("hit latency", cycle - p.acc_cycle, 1);
                        hit_cnt++;
                    end
                end
            end else if (pend_q.size() != 0 && pend_q[0].exp_miss) begin
                check_val("req_ready", req_ready, 1'b0);    // low through a miss
            end
            if (req_valid && req_ready) begin
                if (!flush) begin
                    p.addr      = stim_q[idx].addr;
                    p.exp_miss  = stim_q[idx].exp_miss;
                    p.acc_cycle = cycle;
                    pend_q.push_back(p);
                end
                idx++;
                if (idx < stim_q.size()) begin
                    req.addr <= stim_q[idx].addr;
                    flush    <= stim_q[idx].flush;
                end else begin
                    req_valid <= 1'b0;
                    flush     <= 1'b0;
                end
            end
        end

        repeat (4) begin
            @(posedge clk);
            check_val("rdata_valid", rdata_valid, 1'b0);
            check_val("mem_req_valid", mem_req_valid, 1'b0);
        end
        check_val("hit count", hit_cnt, exp_hits);
        check_val("miss count", miss_cnt, exp_misses);
        check_val("memory handshake total", hs_total, exp_misses);
        $display("hits %0d, misses %0d, memory handshakes %0d", hit_cnt, miss_cnt, hs_total);
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- verif/icache_mem_model.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_mem_model (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   mem_req_valid,
    input  icache_pkg::mem_req_t   mem_req,
    output logic                   mem_addr_ok,
    output logic                   mem_data_ok,
    output icache_pkg::mem_resp_t  mem_rdata
);
    import icache_pkg::*;

    localparam int LINE_WORDS = `ICACHE_LINE_W / 32;

    logic        data_phase;        // address taken, line still owed
    logic [1:0]  wait_cnt;
    logic [31:0] line_addr;
    logic [31:0] rng;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word w of a line holds its own byte address, scrambled
    function automatic mem_resp_t build_line(input logic [31:0] base);
        mem_resp_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l.line[32 * w +: 32] = (base + 4 * w) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    // new address delay, zero means addr_ok is up before the request
    task automatic start_addr_phase();
        rng = xorshift(rng);
        data_phase  <= 1'b0;
        wait_cnt    <= rng[1:0] - 2'd1;
        mem_addr_ok <= (rng[1:0] == 2'd0);
    endtask

    //////////////////////////////
    // address and data phases
    //////////////////////////////

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rng = 32'h9f86_332d;
            start_addr_phase();
            mem_data_ok <= 1'b0;
            mem_rdata   <= '0;
            line_addr   <= '0;
        end else begin
            mem_data_ok <= 1'b0;                // single beat
            if (!data_phase) begin
                if (mem_req_valid && mem_addr_ok) begin
                    line_addr <= mem_req.addr;
                    rng = xorshift(rng);
                    if (rng[1:0] == 2'd0) begin
                        mem_data_ok <= 1'b1;    // line in the very next cycle
                        mem_rdata   <= build_line(mem_req.addr);
                        start_addr_phase();
                    end else begin
                        mem_addr_ok <= 1'b0;
                        data_phase  <= 1'b1;
                        wait_cnt    <= rng[1:0] - 2'd1;
                    end
                end else if (mem_req_valid) begin
                    if (wait_cnt == 2'd0) begin
                        mem_addr_ok <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt - 2'd1;
                    end
                end
            end else if (wait_cnt == 2'd0) begin
                mem_data_ok <= 1'b1;
                mem_rdata   <= build_line(line_addr);
                start_addr_phase();
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        req_valid,
    input  icache_pkg::icache_req_t     req,
    output logic                        req_ready,
    input  logic                        flush,
    output logic                        rdata_valid,
    output icache_pkg::icache_resp_t    rdata,
    output logic                        mem_req_valid,
    output icache_pkg::mem_req_t        mem_req,
    input  logic                        mem_addr_ok,
    input  logic                        mem_data_ok,
    input  icache_pkg::mem_resp_t       mem_rdata
);
    import icache_pkg::*;

    icache_lookup_t              lookup;
    logic                        rbuf_we;
    logic [`ICACHE_WAYS-1:0]     hit;
    logic                        victim_way;
    logic [`ICACHE_WAYS-1:0]     line_we;
    logic                        lru_touch;
    logic                        touch_way;
    logic                        sel_refill;
    logic                        hit_way;
    logic                        resp_en;
    logic [`ICACHE_LINE_W-1:0]   way0_line;
    logic [`ICACHE_LINE_W-1:0]   way1_line;

    //////////////////////////////
    // decode
    //////////////////////////////

    icache_req_buf u_req_buf (
        .clk     (clk),
        .rstn    (rstn),
        .rbuf_we (rbuf_we),
        .req     (req),
        .lookup  (lookup)
    );

    //////////////////////////////
    // arrays
    //////////////////////////////

    icache_tagv_lru u_tagv_lru (
        .clk        (clk),
        .rstn       (rstn),
        .lookup     (lookup),
        .line_we    (line_we),
        .lru_touch  (lru_touch),
        .touch_way  (touch_way),
        .hit        (hit),
        .victim_way (victim_way)
    );

    icache_data_array u_data_array (
        .clk       (clk),
        .lookup    (lookup),
        .line_we   (line_we),
        .mem_rdata (mem_rdata),
        .way0_line (way0_line),
        .way1_line (way1_line)
    );

    //////////////////////////////
    // execute
    //////////////////////////////

    icache_ctrl_fsm u_ctrl_fsm (
        .clk           (clk),
        .rstn          (rstn),
        .req_valid     (req_valid),
        .flush         (flush),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .hit           (hit),
        .victim_way    (victim_way),
        .lookup        (lookup),
        .req_ready     (req_ready),
        .rbuf_we       (rbuf_we),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .line_we       (line_we),
        .lru_touch     (lru_touch),
        .touch_way     (touch_way),
        .sel_refill    (sel_refill),
        .hit_way       (hit_way),
        .resp_en       (resp_en)
    );

    //////////////////////////////
    // result
    //////////////////////////////

    icache_rdata_sel u_rdata_sel (
        .clk         (clk),
        .lookup      (lookup),
        .way0_line   (way0_line),
        .way1_line   (way1_line),
        .mem_rdata   (mem_rdata),
        .sel_refill  (sel_refill),
        .hit_way     (hit_way),
        .resp_en     (resp_en),
        .rdata_valid (rdata_valid),
        .rdata       (rdata)
    );

endmodule

//--- rtl/icache_rdata_sel.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_rdata_sel (
    input  logic                        clk,
    input  icache_pkg::icache_lookup_t  lookup,
    input  logic [`ICACHE_LINE_W-1:0]   way0_line,
    input  logic [`ICACHE_LINE_W-1:0]   way1_line,
    input  icache_pkg::mem_resp_t       mem_rdata,
    input  logic                        sel_refill,
    input  logic                        hit_way,
    input  logic                        resp_en,
    output logic                        rdata_valid,
    output icache_pkg::icache_resp_t    rdata
);

    logic [`ICACHE_LINE_W-1:0] hit_line;
    logic [`ICACHE_LINE_W-1:0] line_sel;

    //////////////////////////////
    // line and word select
    //////////////////////////////

    assign hit_line = hit_way ? way1_line : way0_line;

    // refill data bypasses the array on a miss
    assign line_sel = sel_refill ? mem_rdata.line : hit_line;

    assign rdata.data = line_sel[32 * lookup.offset +: 32];

    // nothing goes back for a squashed lookup
    assign rdata_valid = resp_en;

    // returned word must come from a written line or a real refill beat
    a_rdata_known: assert property (
        @(posedge clk)
        resp_en |-> !$isunknown(rdata)
    ) else $error("icache_rdata_sel: unknown rdata on a response");

endmodule

//--- rtl/icache_ctrl_fsm.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl_fsm (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        req_valid,
    input  logic                        flush,
    input  logic                        mem_addr_ok,
    input  logic                        mem_data_ok,
    input  logic [`ICACHE_WAYS-1:0]     hit,
    input  logic                        victim_way,
    input  icache_pkg::icache_lookup_t  lookup,
    output logic                        req_ready,
    output logic                        rbuf_we,
    output logic                        mem_req_valid,
    output icache_pkg::mem_req_t        mem_req,
    output logic [`ICACHE_WAYS-1:0]     line_we,
    output logic                        lru_touch,
    output logic                        touch_way,
    output logic                        sel_refill,
    output logic                        hit_way,
    output logic                        resp_en
);
    import icache_pkg::*;

    icache_state_e state_q;
    icache_state_e state_d;
    logic          rstn_q;      // reset release seen by one edge
    logic          free;        // current request done, port may take another
    logic          miss;

    assign miss = ~|hit;

    // keeps ready low for the first clock after reset release
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_q <= 1'b0;
        end else begin
            rstn_q <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////
    // next state and outputs
    //////////////////////////////

    always_comb begin
        state_d       = state_q;
        free          = 1'b0;
        rbuf_we       = 1'b0;
        mem_req_valid = 1'b0;
        line_we       = '0;
        lru_touch     = 1'b0;
        touch_way     = 1'b0;
        sel_refill    = 1'b0;
        hit_way       = 1'b0;
        resp_en       = 1'b0;

        case (state_q)
            IDLE, FLUSH: begin
                free = 1'b1;
            end
            LOOKUP: begin
                if (flush) begin
                    free = 1'b1;                // squash, no response and no refill
                end else if (miss) begin
                    mem_req_valid = 1'b1;       // refill request goes out right away
                    state_d       = mem_addr_ok ? MISS_DATA : MISS_ADDR;
                end else begin
                    free      = 1'b1;
                    resp_en   = 1'b1;
                    hit_way   = hit[1];
                    lru_touch = 1'b1;
                    touch_way = hit[1];
                end
            end
            MISS_ADDR: begin
                mem_req_valid = 1'b1;
                if (mem_addr_ok) begin
                    state_d = MISS_DATA;
                end
            end
            MISS_DATA: begin
                // flush is ignored here, the refilled word is still returned
                if (mem_data_ok) begin
                    free       = 1'b1;
                    sel_refill = 1'b1;          // forward straight from memory
                    resp_en    = 1'b1;
                    line_we    = victim_way ? 2'b10 : 2'b01;
                    lru_touch  = 1'b1;
                    touch_way  = victim_way;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // shared accept path
        if (free) begin
            rbuf_we = req_valid & rstn_q & ~flush;
            if (flush) begin
                state_d = FLUSH;                // requests taken now are dropped
            end else if (rbuf_we) begin
                state_d = LOOKUP;
            end else begin
                state_d = IDLE;
            end
        end
    end

    assign req_ready = free & rstn_q;

    // line aligned refill address
    assign mem_req.addr = {lookup.tag, lookup.index, {(`ICACHE_OFFSET_W + 2){1'b0}}};

    //////////////////////////////
    // memory handshake checks
    //////////////////////////////

    a_mem_req_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_addr_ok |=> mem_req_valid
    ) else $error("icache_ctrl_fsm: mem_req_valid dropped before mem_addr_ok");

    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        mem_req_valid && !mem_addr_ok |=> $stable(mem_req)
    ) else $error("icache_ctrl_fsm: mem_req changed while waiting for mem_addr_ok");

endmodule

//--- rtl/icache_data_array.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_data_array (
    input  logic                        clk,
    input  icache_pkg::icache_lookup_t  lookup,
    input  logic [`ICACHE_WAYS-1:0]     line_we,
    input  icache_pkg::mem_resp_t       mem_rdata,
    output logic [`ICACHE_LINE_W-1:0]   way0_line,
    output logic [`ICACHE_LINE_W-1:0]   way1_line
);

    logic [`ICACHE_WAYS-1:0][`ICACHE_LINE_W-1:0] rd_line;

    //////////////////////////////
    // line storage
    //////////////////////////////

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [`ICACHE_LINE_W-1:0] line_q [`ICACHE_SETS];

        always_ff @(posedge clk) begin
            if (line_we[w]) begin
                line_q[lookup.index] <= mem_rdata.line;   // full line refill
            end
        end

        assign rd_line[w] = line_q[lookup.index];   // async read
    end

    assign way0_line = rd_line[0];
    assign way1_line = rd_line[1];

    // only the lru victim is ever refilled
    a_one_way_we: assert property (
        @(posedge clk) line_we != 2'b11
    ) else $error("icache_data_array: both ways written at set %0d", lookup.index);

endmodule

//--- rtl/icache_tagv_lru.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tagv_lru (
    input  logic                        clk,
    input  logic                        rstn,
    input  icache_pkg::icache_lookup_t  lookup,
    input  logic [`ICACHE_WAYS-1:0]     line_we,
    input  logic                        lru_touch,
    input  logic                        touch_way,
    output logic [`ICACHE_WAYS-1:0]     hit,
    output logic                        victim_way
);

    //////////////////////////////
    // tag and valid per way
    //////////////////////////////

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        logic [`ICACHE_TAG_W-1:0] tag_q [`ICACHE_SETS];
        logic [`ICACHE_SETS-1:0]  valid_q;

        // tag written together with the refill line
        always_ff @(posedge clk) begin
            if (line_we[w]) begin
                tag_q[lookup.index] <= lookup.tag;
            end
        end

        always_ff @(posedge clk or negedge rstn) begin
            if (!rstn) begin
                valid_q <= '0;                  // whole cache invalid
            end else if (line_we[w]) begin
                valid_q[lookup.index] <= 1'b1;
            end
        end

        assign hit[w] = valid_q[lookup.index] && (tag_q[lookup.index] == lookup.tag);
    end

    //////////////////////////////
    // lru, one bit per set
    //////////////////////////////

    // holds the way used last
    logic [`ICACHE_SETS-1:0] lru_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (lru_touch) begin
            lru_q[lookup.index] <= touch_way;
        end
    end

    assign victim_way = ~lru_q[lookup.index];   // the other way goes

    // a line is only refilled on a miss in both ways, so
    // one tag can never sit in both ways of a set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (!rstn)
        !(&hit)
    ) else $error("icache_tagv_lru: hit in both ways of set %0d", lookup.index);

endmodule

//--- rtl/icache_req_buf.sv
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_req_buf (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        rbuf_we,
    input  icache_pkg::icache_req_t     req,
    output icache_pkg::icache_lookup_t  lookup
);

    // address of the request in lookup or refill
    logic [31:0] addr_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_q <= 32'h0;
        end else if (rbuf_we) begin
            addr_q <= req.addr;
        end
    end

    //////////////////////////////
    // field split
    //////////////////////////////

    // held through a miss, so refill address and word select do not move
    assign lookup.tag    = addr_q[31 -: `ICACHE_TAG_W];
    assign lookup.index  = addr_q[2 + `ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign lookup.offset = addr_q[2 +: `ICACHE_OFFSET_W];   // word in line

    // fetch must hand over word addresses only
    a_req_aligned: assert property (
        @(posedge clk) disable iff (!rstn)
        rbuf_we |-> (req.addr[1:0] == 2'b00)
    ) else $error("icache_req_buf: unaligned fetch address %h", req.addr);

endmodule

//--- rtl/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

    //////////////////////////////
    // fetch side
    //////////////////////////////

    typedef struct packed {
        logic [31:0] addr;                      // word aligned
    } icache_req_t;

    typedef struct packed {
        logic [31:0] data;                      // instruction word
    } icache_resp_t;

    // request address split for the arrays
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
    } icache_lookup_t;

    //////////////////////////////
    // refill port
    //////////////////////////////

    typedef struct packed {
        logic [31:0] addr;                      // line aligned
    } mem_req_t;

    typedef struct packed {
        logic [`ICACHE_LINE_W-1:0] line;
    } mem_resp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_ADDR,
        MISS_DATA,
        FLUSH
    } icache_state_e;

endpackage

//--- rtl/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

//////////////////////////////
// cache geometry
//////////////////////////////

`define ICACHE_INDEX_W   4                      // 16 sets
`define ICACHE_OFFSET_W  2                      // 4 words per line
`define ICACHE_TAG_W     (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - 2)
`define ICACHE_LINE_W    128
`define ICACHE_WAYS      2                      // lru below assumes two

// derived
`define ICACHE_SETS      (1 << `ICACHE_INDEX_W)

`endif
